//--- include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Register and memory byte width
`define CPU_DATA_BITS      8

// Memory address and program counter width
`define CPU_ADDR_BITS      8

// Register file size and index width
`define CPU_REG_COUNT      16
`define CPU_REG_ADDR_BITS  4

// Instruction word, stored as two bytes high byte first
`define CPU_INSTR_BITS     16

`endif

//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Instruction opcodes in ir[15:12]
    typedef enum logic [3:0] {
        MOVIR = 4'b0000,
        LOAD  = 4'b0010,
        STORE = 4'b0011,
        ADDRR = 4'b0100,
        ADDI  = 4'b0101,
        SUBRR = 4'b0110,
        SUBI  = 4'b0111,
        JNZI  = 4'b1000,
        JZR   = 4'b1001,
        NOP   = 4'b1111
    } opcode_e;

    // Multi-cycle execution stages
    typedef enum logic [2:0] {
        IDLE,
        INSTR_FETCH_START,
        INSTR_FETCH_END,
        REGISTER_FETCH,
        EXECUTE,
        REGISTER_WB,
        STORE_STAGE
    } exec_stage_e;

    // Register file write data source
    typedef enum logic [1:0] {
        ALU_OUTPUT,
        INST_IMMEDIATE,
        MEM_LOAD
    } reg_in_sel_e;

endpackage

`default_nettype wire

//--- source/reg_port_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

interface reg_port_if;

    // Two read ports, answered one edge after rd_en
    logic [`CPU_REG_ADDR_BITS-1:0] rd0_addr;
    logic [`CPU_REG_ADDR_BITS-1:0] rd1_addr;
    logic                          rd_en;
    logic [`CPU_DATA_BITS-1:0]     rd0_data;
    logic [`CPU_DATA_BITS-1:0]     rd1_data;

    // Single write port
    logic                          wr_en;
    logic [`CPU_REG_ADDR_BITS-1:0] wr_addr;
    logic [`CPU_DATA_BITS-1:0]     wr_data;

    modport ctrl (
        output rd0_addr, rd1_addr, rd_en, wr_en, wr_addr, wr_data,
        input  rd0_data, rd1_data
    );

    modport regs (
        input  rd0_addr, rd1_addr, rd_en, wr_en, wr_addr, wr_data,
        output rd0_data, rd1_data
    );

endinterface

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire                       subtract,
    input  wire [`CPU_DATA_BITS-1:0]  a,
    input  wire [`CPU_DATA_BITS-1:0]  b,
    output logic [`CPU_DATA_BITS-1:0] result,
    output logic                      zero
);

    logic [`CPU_DATA_BITS-1:0] sum;

    // Wraps modulo 2^CPU_DATA_BITS
    assign sum = subtract ? (a - b) : (a + b);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result <= '0;
            zero   <= 1'b0;
        end else if (valid) begin
            result <= sum;
            zero   <= (sum == '0);
        end
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module register_file (
    input wire           clk,
    input wire           reset,
    reg_port_if.regs     reg_port
);

    logic [`CPU_DATA_BITS-1:0] rf [`CPU_REG_COUNT];

    // Nonblocking update, so a read of the register being written sees the old value
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rf                <= '{default: '0};
            reg_port.rd0_data <= '0;
            reg_port.rd1_data <= '0;
        end else begin
            if (reg_port.rd_en) begin
                reg_port.rd0_data <= rf[reg_port.rd0_addr];
                reg_port.rd1_data <= rf[reg_port.rd1_addr];
            end
            if (reg_port.wr_en) begin
                rf[reg_port.wr_addr] <= reg_port.wr_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module data_ram (
    input  wire                       clk,

    input  wire                       rd_en,
    input  wire [`CPU_ADDR_BITS-1:0]  rd_addr,
    output logic [`CPU_DATA_BITS-1:0] rd_data,

    input  wire                       wr_en,
    input  wire [`CPU_ADDR_BITS-1:0]  wr_addr,
    input  wire [`CPU_DATA_BITS-1:0]  wr_data,

    input  wire                       load_en,
    input  wire [`CPU_ADDR_BITS-1:0]  load_addr,
    input  wire [`CPU_DATA_BITS-1:0]  load_data
);

    localparam int DEPTH = 1 << `CPU_ADDR_BITS;

    logic [`CPU_DATA_BITS-1:0] mem [DEPTH];

    // Program and data share this array; the load port wins over a core write
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data appears one edge after the request and holds otherwise
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module exec_unit
    import cpu_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       run,

    reg_port_if.ctrl                  reg_port,

    output logic                      rd_en,
    output logic [`CPU_ADDR_BITS-1:0] rd_addr,
    input  wire [`CPU_DATA_BITS-1:0]  rd_data,

    output logic                      wr_en,
    output logic [`CPU_ADDR_BITS-1:0] wr_addr,
    output logic [`CPU_DATA_BITS-1:0] wr_data,

    output logic                      alu_valid,
    output logic                      alu_subtract,
    output logic [`CPU_DATA_BITS-1:0] alu_b,
    input  wire [`CPU_DATA_BITS-1:0]  alu_result,
    input  wire                       alu_zero
);

    exec_stage_e                state;
    logic [`CPU_ADDR_BITS-1:0]  pc;
    logic [`CPU_INSTR_BITS-1:0] ir;
    logic                       zero_flag;
    logic [`CPU_DATA_BITS-1:0]  load_mem;

    opcode_e     opcode;
    reg_in_sel_e reg_in_sel;
    logic        is_arith;
    logic        is_sub;
    logic        is_rr;
    logic        reads_reg;
    logic        writes_back;

    assign opcode = opcode_e'(ir[15:12]);

    // Undefined opcodes leave every flag low and so run as NOP
    always_comb begin
        is_arith    = 1'b0;
        is_sub      = 1'b0;
        is_rr       = 1'b0;
        reads_reg   = 1'b0;
        writes_back = 1'b0;
        case (opcode)
            LOAD: begin
                writes_back = 1'b1;
            end
            STORE, JZR: begin
                reads_reg = 1'b1;
            end
            ADDRR, SUBRR: begin
                is_arith    = 1'b1;
                is_rr       = 1'b1;
                reads_reg   = 1'b1;
                writes_back = 1'b1;
                is_sub      = (opcode == SUBRR);
            end
            ADDI, SUBI: begin
                is_arith    = 1'b1;
                reads_reg   = 1'b1;
                writes_back = 1'b1;
                is_sub      = (opcode == SUBI);
            end
            default: begin
            end
        endcase
    end

    // Memory read requests; the low byte arrives on rd_data in REGISTER_FETCH
    always_comb begin
        rd_en   = 1'b0;
        rd_addr = pc;
        case (state)
            INSTR_FETCH_START: begin
                rd_en = 1'b1;
            end
            INSTR_FETCH_END: begin
                rd_en   = 1'b1;
                rd_addr = pc + 1'b1;
            end
            REGISTER_FETCH: begin
                rd_en   = (opcode == LOAD);
                rd_addr = rd_data;
            end
            default: begin
            end
        endcase
    end

    // Register reads are requested while the low byte is still on rd_data
    assign reg_port.rd_en    = (state == REGISTER_FETCH) && reads_reg;
    assign reg_port.rd0_addr = is_rr ? rd_data[7:4] : ir[11:8];
    assign reg_port.rd1_addr = rd_data[3:0];

    always_comb begin
        case (opcode)
            MOVIR:   reg_in_sel = INST_IMMEDIATE;
            LOAD:    reg_in_sel = MEM_LOAD;
            default: reg_in_sel = ALU_OUTPUT;
        endcase
    end

    always_comb begin
        case (reg_in_sel)
            INST_IMMEDIATE: reg_port.wr_data = ir[7:0];
            MEM_LOAD:       reg_port.wr_data = load_mem;
            default:        reg_port.wr_data = alu_result;
        endcase
    end

    assign reg_port.wr_en = ((state == EXECUTE) && (opcode == MOVIR)) ||
                            ((state == REGISTER_WB) && writes_back);
    assign reg_port.wr_addr = ir[11:8];

    assign alu_valid    = (state == EXECUTE) && is_arith;
    assign alu_subtract = is_sub;
    assign alu_b        = is_rr ? reg_port.rd1_data : ir[7:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            pc        <= '0;
            ir        <= {NOP, 12'h000};
            zero_flag <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state <= INSTR_FETCH_START;
                    end
                end
                INSTR_FETCH_START: begin
                    state <= INSTR_FETCH_END;
                end
                INSTR_FETCH_END: begin
                    ir[15:8] <= rd_data;
                    state    <= REGISTER_FETCH;
                end
                REGISTER_FETCH: begin
                    ir[7:0] <= rd_data;
                    // JNZI target is the low byte itself
                    if ((opcode == JNZI) && !zero_flag) begin
                        pc <= rd_data;
                    end else begin
                        pc <= pc + 2'd2;
                    end
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    if ((opcode == JZR) && zero_flag) begin
                        pc <= reg_port.rd0_data;
                    end
                    if (opcode == STORE) begin
                        wr_en <= 1'b1;
                        state <= STORE_STAGE;
                    end else if (writes_back) begin
                        state <= REGISTER_WB;
                    end else begin
                        state <= INSTR_FETCH_START;
                    end
                end
                REGISTER_WB: begin
                    // Only arithmetic results move the zero flag
                    if (is_arith) begin
                        zero_flag <= alu_zero;
                    end
                    state <= INSTR_FETCH_START;
                end
                STORE_STAGE: begin
                    wr_en <= 1'b0;
                    state <= INSTR_FETCH_START;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Store payload and loaded byte, captured in EXECUTE
    always_ff @(posedge clk) begin
        if (state == EXECUTE) begin
            if (opcode == STORE) begin
                wr_addr <= ir[7:0];
                wr_data <= reg_port.rd0_data;
            end
            if (opcode == LOAD) begin
                load_mem <= rd_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       run,

    input  wire                       load_en,
    input  wire [`CPU_ADDR_BITS-1:0]  load_addr,
    input  wire [`CPU_DATA_BITS-1:0]  load_data,

    output logic                      store_en,
    output logic [`CPU_ADDR_BITS-1:0] store_addr,
    output logic [`CPU_DATA_BITS-1:0] store_data
);

    logic                      mem_rd_en;
    logic [`CPU_ADDR_BITS-1:0] mem_rd_addr;
    logic [`CPU_DATA_BITS-1:0] mem_rd_data;
    logic                      mem_wr_en;
    logic [`CPU_ADDR_BITS-1:0] mem_wr_addr;
    logic [`CPU_DATA_BITS-1:0] mem_wr_data;

    logic                      alu_valid;
    logic                      alu_subtract;
    logic [`CPU_DATA_BITS-1:0] alu_b;
    logic [`CPU_DATA_BITS-1:0] alu_result;
    logic                      alu_zero;

    reg_port_if reg_bus ();

    exec_unit i_exec_unit (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .reg_port     (reg_bus),
        .rd_en        (mem_rd_en),
        .rd_addr      (mem_rd_addr),
        .rd_data      (mem_rd_data),
        .wr_en        (mem_wr_en),
        .wr_addr      (mem_wr_addr),
        .wr_data      (mem_wr_data),
        .alu_valid    (alu_valid),
        .alu_subtract (alu_subtract),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .alu_zero     (alu_zero)
    );

    alu i_alu (
        .clk      (clk),
        .reset    (reset),
        .valid    (alu_valid),
        .subtract (alu_subtract),
        .a        (reg_bus.rd0_data),
        .b        (alu_b),
        .result   (alu_result),
        .zero     (alu_zero)
    );

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .reg_port (reg_bus)
    );

    data_ram i_data_ram (
        .clk       (clk),
        .rd_en     (mem_rd_en),
        .rd_addr   (mem_rd_addr),
        .rd_data   (mem_rd_data),
        .wr_en     (mem_wr_en),
        .wr_addr   (mem_wr_addr),
        .wr_data   (mem_wr_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // Every core write is visible outside as a store
    assign store_en   = mem_wr_en;
    assign store_addr = mem_wr_addr;
    assign store_data = mem_wr_data;

endmodule

`default_nettype wire

//--- verification/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props
    import cpu_pkg::*;
(
    input wire              clk,
    input wire              reset,
    input wire              run,
    input wire exec_stage_e state,
    input wire reg_in_sel_e reg_in_sel,
    input wire              rd_en,
    input wire              wr_en
);

    // Memory write strobe is a single-cycle pulse
    a_store_pulse: assert property (@(posedge clk) disable iff (reset)
        $rose(wr_en) |=> !wr_en)
        else $error("memory write enable stayed high for more than one cycle");

    // One shared memory port, never read and written together
    a_port_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(rd_en && wr_en))
        else $error("memory read and write enables were high in the same cycle");

    a_idle_hold: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && !run) |=> state == IDLE)
        else $error("core left IDLE while run was low");

    // Writeback stage carries ALU or load data, never the immediate
    a_wb_source: assert property (@(posedge clk) disable iff (reset)
        (state == REGISTER_WB) |-> reg_in_sel != INST_IMMEDIATE)
        else $error("register writeback selected the immediate as its source");

endmodule

bind exec_unit cpu_props i_cpu_props (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .state      (state),
    .reg_in_sel (reg_in_sel),
    .rd_en      (rd_en),
    .wr_en      (wr_en)
);

`default_nettype wire

//--- verification/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int MEM_BYTES        = 1 << `CPU_ADDR_BITS;
    localparam int MODEL_STEP_LIMIT = 4000;

    logic                      clk;
    logic                      reset;
    logic                      run;
    logic                      load_en;
    logic [`CPU_ADDR_BITS-1:0] load_addr;
    logic [`CPU_DATA_BITS-1:0] load_data;
    logic                      store_en;
    logic [`CPU_ADDR_BITS-1:0] store_addr;
    logic [`CPU_DATA_BITS-1:0] store_data;

    integer seed = 32'h1608_47b9;

    logic [`CPU_DATA_BITS-1:0] image [MEM_BYTES];
    logic [`CPU_ADDR_BITS-1:0] prog_pc;
    logic [3:0]                store_slot;

    logic [`CPU_ADDR_BITS-1:0] exp_addr_q [$];
    logic [`CPU_DATA_BITS-1:0] exp_data_q [$];

    int   cycle_count = 0;
    int   test_start  = 0;
    int   test_limit  = 0;
    logic test_active = 1'b0;

    cpu_top i_cpu_top (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_store(
        input logic [`CPU_ADDR_BITS-1:0] got_addr,
        input logic [`CPU_DATA_BITS-1:0] got_data,
        input logic [`CPU_ADDR_BITS-1:0] want_addr,
        input logic [`CPU_DATA_BITS-1:0] want_data
    );
        if (got_addr !== want_addr || got_data !== want_data) begin
            report_failure($sformatf("ERR %0t: store of %02h to %02h, expected %02h to %02h",
                                     $time, got_data, got_addr, want_data, want_addr));
        end
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Instruction-level model that fills the expected store queues, 0 means no end loop
    function automatic int run_model();
        logic [7:0] m [MEM_BYTES];
        logic [7:0] r [`CPU_REG_COUNT];
        logic [7:0] pc;
        logic [7:0] next_pc;
        logic [7:0] low;
        logic [3:0] op;
        logic [3:0] rd;
        logic       z;
        logic       finished;
        int         steps;
        m        = image;
        r        = '{default: '0};
        pc       = '0;
        z        = 1'b0;
        finished = 1'b0;
        steps    = 0;
        exp_addr_q.delete();
        exp_data_q.delete();
        while (!finished && steps < MODEL_STEP_LIMIT) begin
            op      = m[pc][7:4];
            rd      = m[pc][3:0];
            low     = m[pc + 8'd1];
            next_pc = pc + 8'd2;
            steps++;
            case (op)
                MOVIR: r[rd] = low;
                LOAD:  r[rd] = m[low];
                STORE: begin
                    m[low] = r[rd];
                    exp_addr_q.push_back(low);
                    exp_data_q.push_back(r[rd]);
                end
                ADDRR: begin
                    r[rd] = r[low[7:4]] + r[low[3:0]];
                    z     = (r[rd] == 8'd0);
                end
                ADDI: begin
                    r[rd] = r[rd] + low;
                    z     = (r[rd] == 8'd0);
                end
                SUBRR: begin
                    r[rd] = r[low[7:4]] - r[low[3:0]];
                    z     = (r[rd] == 8'd0);
                end
                SUBI: begin
                    r[rd] = r[rd] - low;
                    z     = (r[rd] == 8'd0);
                end
                JNZI: begin
                    // A taken jump to itself never leaves again
                    finished = !z && (low == pc);
                    if (!z) next_pc = low;
                end
                JZR: begin
                    if (z) next_pc = r[rd];
                end
                default: begin
                end
            endcase
            pc = next_pc;
        end
        return finished ? steps : 0;
    endfunction

    task automatic clear_image();
        int a;
        for (a = 0; a < MEM_BYTES; a++) begin
            image[a[7:0]] = {a[3:0], a[7:4]} ^ 8'h3C;
        end
        prog_pc    = '0;
        store_slot = '0;
    endtask

    task automatic emit(input logic [3:0] op, input logic [3:0] rd, input logic [7:0] low);
        image[prog_pc]         = {op, rd};
        image[prog_pc + 8'd1]  = low;
        prog_pc                = prog_pc + 8'd2;
    endtask

    // Each store of a test gets its own slot in 0x80..0xFF
    task automatic emit_store(input logic [3:0] rs);
        logic [7:0] r;
        r = rand_byte();
        emit(STORE, rs, {1'b1, store_slot, r[2:0]});
        store_slot = store_slot + 4'd1;
    endtask

    task automatic emit_end();
        emit(MOVIR, 4'd15, 8'd2);
        emit(SUBI, 4'd15, 8'd1);
        emit(JNZI, 4'd0, prog_pc);
    endtask

    task automatic run_test(input string name);
        int n_instr;
        int n_stores;
        int a;
        n_instr  = run_model();
        n_stores = exp_addr_q.size();
        if (n_instr == 0) begin
            report_failure({"Reference model of test ", name, " never reached its end loop"});
        end else begin
            @(posedge clk);
            reset   <= 1'b1;
            run     <= 1'b0;
            load_en <= 1'b0;
            repeat (3) @(posedge clk);
            reset <= 1'b0;
            for (a = 0; a < MEM_BYTES; a++) begin
                load_en   <= 1'b1;
                load_addr <= a[7:0];
                load_data <= image[a[7:0]];
                @(posedge clk);
            end
            load_en     <= 1'b0;
            run         <= 1'b1;
            test_start  <= cycle_count;
            test_limit  <= 6 * n_instr + 100;
            test_active <= 1'b1;
            while (exp_addr_q.size() != 0) begin
                @(posedge clk);
            end
            // Window for a store that should not happen
            repeat (20) @(posedge clk);
            test_active <= 1'b0;
            run         <= 1'b0;
            $display("%s: %0d instructions, %0d stores checked", name, n_instr, n_stores);
        end
    endtask

    task automatic store_all_registers();
        int i;
        clear_image();
        for (i = 0; i < 16; i++) begin
            emit(MOVIR, i[3:0], rand_byte());
            emit_store(i[3:0]);
        end
        emit_end();
        run_test("movir_store");
    endtask

    task automatic wrap_arithmetic();
        int k;
        logic [7:0] a, b, x, y, c, d;
        clear_image();
        for (k = 0; k < 4; k++) begin
            if (k == 0) begin
                // Wrap past 255 on the adds and below 0 on the subtracts
                a = 8'hF0;
                x = 8'h20;
                b = 8'h05;
                y = 8'h10;
                c = 8'h30;
                d = 8'hE0;
            end else begin
                a = rand_byte();
                x = rand_byte();
                b = rand_byte();
                y = rand_byte();
                c = rand_byte();
                d = rand_byte();
            end
            emit(MOVIR, 4'd1, a);
            emit(MOVIR, 4'd2, b);
            emit(ADDI, 4'd1, x);
            emit_store(4'd1);
            emit(SUBI, 4'd2, y);
            emit_store(4'd2);
            emit(MOVIR, 4'd3, c);
            emit(MOVIR, 4'd4, d);
            emit(ADDRR, 4'd5, {4'd3, 4'd4});
            emit_store(4'd5);
            emit(SUBRR, 4'd6, {4'd3, 4'd4});
            emit_store(4'd6);
        end
        emit_end();
        run_test("arith");
    endtask

    task automatic load_and_compute();
        clear_image();
        image[8'hF0] = rand_byte();
        image[8'hF1] = rand_byte();
        emit(LOAD, 4'd7, 8'hF0);
        emit_store(4'd7);
        emit(ADDI, 4'd7, rand_byte());
        emit_store(4'd7);
        emit(LOAD, 4'd8, 8'hF1);
        emit(SUBRR, 4'd9, {4'd8, 4'd7});
        emit_store(4'd9);
        // The fill pattern comes back from this untouched byte
        emit(LOAD, 4'd10, 8'hF2);
        emit_store(4'd10);
        emit_end();
        run_test("load");
    endtask

    task automatic count_down();
        logic [7:0] n;
        logic [7:0] loop_pc;
        clear_image();
        n = 8'd5 + (rand_byte() % 8'd6);
        emit(MOVIR, 4'd2, n);
        loop_pc = prog_pc;
        emit_store(4'd2);
        emit(SUBI, 4'd2, 8'd1);
        emit(JNZI, 4'd0, loop_pc);
        emit_end();
        run_test("countdown");
    endtask

    task automatic jump_on_zero();
        int k;
        logic [7:0] v, w;
        logic [7:0] coin;
        clear_image();
        emit(MOVIR, 4'd11, 8'hAA);
        emit(MOVIR, 4'd12, 8'h55);
        for (k = 0; k < 4; k++) begin
            v = rand_byte();
            if (k == 0) begin
                w = v;
            end else if (k == 1) begin
                w = v + 8'd1;
            end else begin
                coin = rand_byte();
                w    = coin[0] ? v : rand_byte();
            end
            emit(MOVIR, 4'd1, v);
            emit(SUBI, 4'd1, w);
            // Target skips the first marker store
            emit(MOVIR, 4'd10, prog_pc + 8'd6);
            emit(JZR, 4'd10, 8'h00);
            emit_store(4'd11);
            emit_store(4'd12);
        end
        emit_end();
        run_test("jzr");
    endtask

    task automatic skip_undefined_opcodes();
        int i;
        logic [7:0] r;
        logic [3:0] op;
        clear_image();
        for (i = 0; i < 16; i++) begin
            emit(MOVIR, i[3:0], rand_byte());
        end
        for (i = 0; i < 16; i++) begin
            r = rand_byte();
            case (r[2:0])
                3'd0:    op = 4'h1;
                3'd1:    op = 4'hA;
                3'd2:    op = 4'hB;
                3'd3:    op = 4'hC;
                3'd4:    op = 4'hD;
                3'd5:    op = 4'hE;
                default: op = NOP;
            endcase
            emit(op, r[7:4], rand_byte());
        end
        for (i = 0; i < 16; i++) begin
            emit_store(i[3:0]);
        end
        emit_end();
        run_test("filler");
    endtask

    // Store checker
    always @(posedge clk) begin
        if (!reset && store_en) begin
            if (exp_addr_q.size() == 0) begin
                report_failure($sformatf("Unexpected extra store of %02h to address %02h",
                                         store_data, store_addr));
            end else begin
                check_store(store_addr, store_data, exp_addr_q.pop_front(),
                            exp_data_q.pop_front());
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (test_active && (cycle_count - test_start > test_limit)) begin
            report_failure($sformatf("Timeout: test did not finish within %0d cycles",
                                     test_limit));
        end
    end

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        store_all_registers();
        wrap_arithmetic();
        load_and_compute();
        count_down();
        jump_on_zero();
        skip_undefined_opcodes();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
source/cpu_pkg.sv
source/reg_port_if.sv
source/alu.sv
source/register_file.sv
source/data_ram.sv
source/exec_unit.sv
source/cpu_top.sv
verification/cpu_props.sv
verification/tb_cpu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --timing --assert

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard source/*.sv verification/*.sv include/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a pass report, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
